// ==== mem_subsys.f ====
+incdir+rtl
rtl/mem_pkg.sv
rtl/main_memory.sv
rtl/mem_arbiter.sv
rtl/mem_subsys.sv
tests/tb_clock_gen.sv
tests/mem_subsys_sva.sv
tests/mem_subsys_tb.sv

// ==== rtl/main_memory.sv ====
`timescale 1ns/1ns
`include "mem_consts.svh"

module main_memory (
    input  logic          clk,
    input  logic          rst,
    input  logic          cmd_start,
    input  logic          cmd_write,
    input  mem_pkg::word_t addr,
    input  mem_pkg::word_t wdata,
    input  mem_pkg::word_t wmask,
    output logic          cmd_ready,
    output mem_pkg::word_t rdata,
    output logic          rdata_valid
);

    localparam int LAT   = `MEM_READ_LATENCY;
    localparam int CNT_W = $clog2(LAT + 1);
    localparam int IDX_W = $clog2(`MEM_WORDS);

    mem_pkg::word_t mem [0:`MEM_WORDS-1];

    logic [IDX_W-1:0] idx;
    logic             accept;
    logic [CNT_W-1:0] rd_cnt;       // cycles left until read data
    logic             wr_busy;      // one dead cycle after a write
    mem_pkg::word_t   rd_word;      // word captured at read acceptance
    mem_pkg::word_t   merged;

    // memory comes up cleared
    initial begin
        for (int i = 0; i < `MEM_WORDS; i++) begin
            mem[i] = '0;
        end
    end

    assign idx    = addr[`MEM_ADDR_SHIFT +: IDX_W];
    assign accept = cmd_start && cmd_ready;
    assign merged = (mem[idx] & ~wmask) | (wdata & wmask);  // bitwise merge

    // ready comes back in the valid cycle so a queued command can go at once
    assign cmd_ready = !wr_busy && (rd_cnt < CNT_W'(2));

    assign rdata_valid = (rd_cnt == CNT_W'(1));
    assign rdata       = rdata_valid ? rd_word : `MEM_IDLE_DATA;

    always_ff @(posedge clk) begin
        if (rst) begin
            rd_cnt  <= '0;
            wr_busy <= 1'b0;
        end else begin
            wr_busy <= accept && cmd_write;
            if (accept && !cmd_write) begin
                rd_cnt <= CNT_W'(LAT);  // start read latency
            end else if (rd_cnt != '0) begin
                rd_cnt <= rd_cnt - CNT_W'(1);
            end
        end
    end

    // array and read word
    always_ff @(posedge clk) begin
        if (accept && cmd_write) begin
            mem[idx] <= merged;
        end
        if (accept && !cmd_write) begin
            rd_word <= mem[idx];
        end
    end

endmodule

// ==== rtl/mem_arbiter.sv ====
`timescale 1ns/1ns
`include "mem_consts.svh"

module mem_arbiter (
    input  logic           clk,
    input  logic           rst,
    input  logic           halt,

    input  logic           inst_start,
    input  mem_pkg::word_t i_addr,
    output logic           inst_ready,
    output mem_pkg::word_t inst,
    output logic           inst_valid,

    input  logic           d_cmd_start,
    input  logic           d_cmd_write,
    input  mem_pkg::word_t d_addr,
    input  mem_pkg::word_t wdata,
    input  mem_pkg::word_t wmask,
    output logic           d_cmd_ready,
    output mem_pkg::word_t rdata,
    output logic           rdata_valid,

    output logic           mem_cmd_start,
    output logic           mem_cmd_write,
    output mem_pkg::word_t mem_addr,
    output mem_pkg::word_t mem_wdata,
    output mem_pkg::word_t mem_wmask,
    input  logic           mem_cmd_ready,
    input  mem_pkg::word_t mem_rdata,
    input  logic           mem_rdata_valid
);

    mem_pkg::arb_state_t state;
    mem_pkg::req_kind_t  kind;          // access now in progress

    // request fields captured in wait_cmd
    logic           hold_d_start;
    logic           hold_d_write;
    mem_pkg::word_t hold_i_addr;
    mem_pkg::word_t hold_d_addr;
    mem_pkg::word_t hold_wdata;
    mem_pkg::word_t hold_wmask;

    logic fetch_done;
    logic load_done;
    logic issue_held;

    // where a data command goes once it is offered to the memory
    function automatic mem_pkg::arb_state_t data_next(input logic ready, input logic write);
        if (!ready) begin
            return mem_pkg::wait_ready;
        end
        return write ? mem_pkg::wait_cmd : mem_pkg::wait_read;  // writes finish on accept
    endfunction

    assign inst_ready  = (state == mem_pkg::wait_cmd);
    assign d_cmd_ready = (state == mem_pkg::wait_cmd);

    assign fetch_done = (state == mem_pkg::wait_read) && mem_rdata_valid
                        && (kind == mem_pkg::kind_inst);
    assign load_done  = (state == mem_pkg::wait_read) && mem_rdata_valid
                        && (kind == mem_pkg::kind_data);
    assign issue_held = fetch_done && hold_d_start && mem_cmd_ready;  // data cmd behind a fetch

    // command onto the memory
    always_comb begin
        mem_cmd_start = 1'b0;
        mem_cmd_write = 1'b0;
        mem_addr      = hold_d_addr;
        mem_wdata     = hold_wdata;
        mem_wmask     = hold_wmask;
        case (state)
            mem_pkg::wait_cmd: begin
                mem_cmd_start = !halt && mem_cmd_ready && (inst_start || d_cmd_start);
                mem_cmd_write = !inst_start && d_cmd_write;  // fetch wins
                mem_addr      = inst_start ? i_addr : d_addr;
                mem_wdata     = wdata;
                mem_wmask     = wmask;
            end
            mem_pkg::wait_ready: begin
                mem_cmd_start = !halt && mem_cmd_ready;
                mem_cmd_write = (kind == mem_pkg::kind_data) && hold_d_write;
                mem_addr      = (kind == mem_pkg::kind_inst) ? hold_i_addr : hold_d_addr;
            end
            mem_pkg::wait_read: begin
                mem_cmd_start = !halt && issue_held;
                mem_cmd_write = hold_d_write;
            end
            default: begin
                mem_cmd_start = 1'b0;
            end
        endcase
    end

    // state, request kind and response registers
    always_ff @(posedge clk) begin
        if (rst) begin
            state        <= mem_pkg::wait_cmd;
            kind         <= mem_pkg::kind_inst;
            hold_d_start <= 1'b0;
            inst_valid   <= 1'b0;
            rdata_valid  <= 1'b0;
            inst         <= `MEM_IDLE_DATA;
            rdata        <= `MEM_IDLE_DATA;
        end else begin
            inst_valid  <= 1'b0;  // pulses
            rdata_valid <= 1'b0;
            if (!halt) begin
                case (state)
                    mem_pkg::wait_cmd: begin
                        hold_d_start <= d_cmd_start;
                        if (inst_start) begin
                            kind  <= mem_pkg::kind_inst;
                            state <= mem_cmd_ready ? mem_pkg::wait_read : mem_pkg::wait_ready;
                        end else if (d_cmd_start) begin
                            kind  <= mem_pkg::kind_data;
                            state <= data_next(mem_cmd_ready, d_cmd_write);
                        end
                    end
                    mem_pkg::wait_ready: begin
                        if (mem_cmd_ready) begin
                            if (kind == mem_pkg::kind_inst) begin
                                state <= mem_pkg::wait_read;
                            end else begin
                                state <= data_next(1'b1, hold_d_write);
                            end
                        end
                    end
                    mem_pkg::wait_read: begin
                        if (fetch_done) begin
                            inst       <= mem_rdata;
                            inst_valid <= 1'b1;
                            if (hold_d_start) begin
                                kind  <= mem_pkg::kind_data;  // held data cmd is next
                                state <= data_next(mem_cmd_ready, hold_d_write);
                            end else begin
                                state <= mem_pkg::wait_cmd;
                            end
                        end else if (load_done) begin
                            rdata       <= mem_rdata;
                            rdata_valid <= 1'b1;
                            state       <= mem_pkg::wait_cmd;
                        end
                    end
                    default: begin
                        state <= mem_pkg::wait_cmd;
                    end
                endcase
            end
        end
    end

    // request payload, taken whenever idle
    always_ff @(posedge clk) begin
        if (!halt && (state == mem_pkg::wait_cmd)) begin
            hold_d_write <= d_cmd_write;
            hold_i_addr  <= i_addr;
            hold_d_addr  <= d_addr;
            hold_wdata   <= wdata;
            hold_wmask   <= wmask;
        end
    end

endmodule

// ==== rtl/mem_consts.svh ====
`ifndef MEM_CONSTS_SVH
`define MEM_CONSTS_SVH

// main memory depth in 32-bit words (4096 bytes)
`define MEM_WORDS 1024

// cycles from read acceptance to read valid
`define MEM_READ_LATENCY 2

// byte address to word index
`define MEM_ADDR_SHIFT 2

// read data bus value while no read returns
`define MEM_IDLE_DATA 32'hffff_ffff

`endif

// ==== rtl/mem_pkg.sv ====
package mem_pkg;

    // data, address and mask words all share this
    typedef logic [31:0] word_t;

    typedef enum logic [1:0] {
        wait_cmd   = 2'd0,  // idle, both ready outputs high
        wait_ready = 2'd1,  // request held, memory busy
        wait_read  = 2'd2   // read issued, waiting for data
    } arb_state_t;

    typedef enum logic {
        kind_inst = 1'b0,   // instruction fetch
        kind_data = 1'b1    // data load or store
    } req_kind_t;

endpackage

// ==== rtl/mem_subsys.sv ====
`timescale 1ns/1ns

module mem_subsys (
    input  logic           clk,
    input  logic           rst,
    input  logic           halt,

    input  logic           inst_start,
    input  mem_pkg::word_t i_addr,
    output logic           inst_ready,
    output mem_pkg::word_t inst,
    output logic           inst_valid,

    input  logic           d_cmd_start,
    input  logic           d_cmd_write,
    input  mem_pkg::word_t d_addr,
    input  mem_pkg::word_t wdata,
    input  mem_pkg::word_t wmask,
    output logic           d_cmd_ready,
    output mem_pkg::word_t rdata,
    output logic           rdata_valid
);

    // arbiter to memory
    logic           mem_cmd_start;
    logic           mem_cmd_write;
    mem_pkg::word_t mem_addr;
    mem_pkg::word_t mem_wdata;
    mem_pkg::word_t mem_wmask;

    // memory to arbiter
    logic           mem_cmd_ready;
    mem_pkg::word_t mem_rdata;
    logic           mem_rdata_valid;

    mem_arbiter mem_arbiter_inst (
        .clk             (clk),
        .rst             (rst),
        .halt            (halt),
        .inst_start      (inst_start),
        .i_addr          (i_addr),
        .inst_ready      (inst_ready),
        .inst            (inst),
        .inst_valid      (inst_valid),
        .d_cmd_start     (d_cmd_start),
        .d_cmd_write     (d_cmd_write),
        .d_addr          (d_addr),
        .wdata           (wdata),
        .wmask           (wmask),
        .d_cmd_ready     (d_cmd_ready),
        .rdata           (rdata),
        .rdata_valid     (rdata_valid),
        .mem_cmd_start   (mem_cmd_start),
        .mem_cmd_write   (mem_cmd_write),
        .mem_addr        (mem_addr),
        .mem_wdata       (mem_wdata),
        .mem_wmask       (mem_wmask),
        .mem_cmd_ready   (mem_cmd_ready),
        .mem_rdata       (mem_rdata),
        .mem_rdata_valid (mem_rdata_valid)
    );

    main_memory main_memory_inst (
        .clk         (clk),
        .rst         (rst),
        .cmd_start   (mem_cmd_start),
        .cmd_write   (mem_cmd_write),
        .addr        (mem_addr),
        .wdata       (mem_wdata),
        .wmask       (mem_wmask),
        .cmd_ready   (mem_cmd_ready),
        .rdata       (mem_rdata),
        .rdata_valid (mem_rdata_valid)
    );

endmodule

// ==== tests/mem_subsys_sva.sv ====
`timescale 1ns/1ns

module mem_subsys_sva (
    input logic clk,
    input logic rst,
    input logic halt,
    input logic inst_ready,
    input logic d_cmd_ready,
    input logic inst_valid,
    input logic rdata_valid,
    input logic mem_cmd_start,
    input logic mem_cmd_write,
    input logic mem_cmd_ready
);

    int assert_failures = 0;

    valid_exclusive: assert property (@(posedge clk) disable iff (rst)
        !(inst_valid && rdata_valid))
    else begin
        assert_failures++;
        $error("inst_valid and rdata_valid high in the same cycle");
    end

    // a read in flight keeps both request sides waiting
    ready_low_on_read: assert property (@(posedge clk) disable iff (rst)
        (mem_cmd_start && !mem_cmd_write) |=> !(inst_ready || d_cmd_ready))
    else begin
        assert_failures++;
        $error("ready output high while a read is in flight");
    end

    // memory only takes a command while ready
    start_needs_ready: assert property (@(posedge clk) disable iff (rst)
        mem_cmd_start |-> mem_cmd_ready)
    else begin
        assert_failures++;
        $error("mem_cmd_start high while mem_cmd_ready low");
    end

    halt_no_valid: assert property (@(posedge clk) disable iff (rst)
        (halt && $past(halt)) |-> !(inst_valid || rdata_valid))
    else begin
        assert_failures++;
        $error("valid pulse raised while halted");
    end

endmodule

// ==== tests/mem_subsys_tb.sv ====
`timescale 1ns/1ns
`include "mem_consts.svh"

module mem_subsys_tb;

    localparam int TIMEOUT    = 200;  // cycles per wait
    localparam int RANDOM_OPS = 400;

    logic           clk;
    logic           rst;
    logic           halt;
    logic           inst_start;
    mem_pkg::word_t i_addr;
    logic           inst_ready;
    mem_pkg::word_t inst;
    logic           inst_valid;
    logic           d_cmd_start;
    logic           d_cmd_write;
    mem_pkg::word_t d_addr;
    mem_pkg::word_t wdata;
    mem_pkg::word_t wmask;
    logic           d_cmd_ready;
    mem_pkg::word_t rdata;
    logic           rdata_valid;

    mem_pkg::word_t model [0:`MEM_WORDS-1];  // reference memory
    logic [31:0]    rng_state;
    mem_pkg::word_t last_inst;
    mem_pkg::word_t last_rdata;
    logic           have_inst;
    logic           have_rdata;
    int             value_errors;
    int             other_errors;
    int             timeouts;

    tb_clock_gen clock_gen_inst (.clk(clk));

    mem_subsys mem_subsys_inst (
        .clk         (clk),
        .rst         (rst),
        .halt        (halt),
        .inst_start  (inst_start),
        .i_addr      (i_addr),
        .inst_ready  (inst_ready),
        .inst        (inst),
        .inst_valid  (inst_valid),
        .d_cmd_start (d_cmd_start),
        .d_cmd_write (d_cmd_write),
        .d_addr      (d_addr),
        .wdata       (wdata),
        .wmask       (wmask),
        .d_cmd_ready (d_cmd_ready),
        .rdata       (rdata),
        .rdata_valid (rdata_valid)
    );

    bind mem_subsys mem_subsys_sva mem_subsys_sva_inst (
        .clk           (clk),
        .rst           (rst),
        .halt          (halt),
        .inst_ready    (inst_ready),
        .d_cmd_ready   (d_cmd_ready),
        .inst_valid    (inst_valid),
        .rdata_valid   (rdata_valid),
        .mem_cmd_start (mem_cmd_start),
        .mem_cmd_write (mem_cmd_write),
        .mem_cmd_ready (mem_cmd_ready)
    );

    function automatic logic [31:0] xorshift(input logic [31:0] s);
        logic [31:0] x;
        x = s;
        x = x ^ (x << 13);
        x = x ^ (x >> 17);
        x = x ^ (x << 5);
        return x;
    endfunction

    function automatic mem_pkg::word_t random_word();
        rng_state = xorshift(rng_state);
        return rng_state;
    endfunction

    // half the accesses hit a small window so loads see earlier writes
    function automatic int random_index();
        mem_pkg::word_t r;
        r = random_word();
        if (r[31]) begin
            return int'(r[3:0]);
        end
        return int'(r % `MEM_WORDS);
    endfunction

    function automatic mem_pkg::word_t byte_addr(input int idx);
        return mem_pkg::word_t'(idx) << `MEM_ADDR_SHIFT;
    endfunction

    // each set mask bit takes the data bit
    function automatic mem_pkg::word_t merge_masked(input mem_pkg::word_t old_word,
                                                    input mem_pkg::word_t data,
                                                    input mem_pkg::word_t mask);
        mem_pkg::word_t result;
        for (int b = 0; b < 32; b++) begin
            result[b] = mask[b] ? data[b] : old_word[b];
        end
        return result;
    endfunction

    task automatic check_value(input string name, input mem_pkg::word_t expected,
                               input mem_pkg::word_t actual);
        if (actual !== expected) begin
            $display("[FAIL] %s: expected %h, actual %h", name, expected, actual);
            value_errors++;
        end
    endtask

    // waits at falling edges until the arbiter is idle
    task automatic wait_idle();
        int n;
        n = 0;
        do begin
            @(negedge clk);
            n++;
            if (inst_valid || rdata_valid) begin
                $display("error: valid pulse with no request outstanding");
                other_errors++;
            end
        end while (inst_ready !== 1'b1 && n < TIMEOUT);
        if (inst_ready !== 1'b1) begin
            $display("error: arbiter did not return to idle within %0d cycles", TIMEOUT);
            timeouts++;
        end
    endtask

    task automatic drive_request(input logic fetch, input logic data, input logic write,
                                 input int i_idx, input int d_idx,
                                 input mem_pkg::word_t wd, input mem_pkg::word_t wm);
        @(posedge clk);
        inst_start  <= fetch;
        i_addr      <= byte_addr(i_idx);
        d_cmd_start <= data;
        d_cmd_write <= write;
        d_addr      <= byte_addr(d_idx);
        wdata       <= wd;
        wmask       <= wm;
    endtask

    task automatic release_request();
        @(posedge clk);  // request taken at this edge
        inst_start  <= 1'b0;
        d_cmd_start <= 1'b0;
    endtask

    task automatic collect_responses(input string name, input logic want_inst,
                                     input logic want_rdata, input mem_pkg::word_t exp_inst,
                                     input mem_pkg::word_t exp_rdata);
        int   n;
        logic got_inst;
        logic got_rdata;
        logic done;
        n = 0;
        got_inst = 1'b0;
        got_rdata = 1'b0;
        done = 1'b0;
        while (!done && n < TIMEOUT) begin
            @(negedge clk);
            n++;
            if (inst_valid) begin
                if (!want_inst || got_inst) begin
                    $display("error: %s gave an unexpected inst_valid pulse", name);
                    other_errors++;
                end
                check_value({name, " inst"}, exp_inst, inst);
                got_inst = 1'b1;
            end
            if (rdata_valid) begin
                if (!want_rdata || got_rdata) begin
                    $display("error: %s gave an unexpected rdata_valid pulse", name);
                    other_errors++;
                end
                if (want_inst && !got_inst) begin
                    $display("error: %s returned load data before the fetch", name);
                    other_errors++;
                end
                check_value({name, " rdata"}, exp_rdata, rdata);
                got_rdata = 1'b1;
            end
            done = (got_inst == want_inst) && (got_rdata == want_rdata) && inst_ready;
        end
        if (!done) begin
            $display("error: %s did not complete within %0d cycles", name, TIMEOUT);
            timeouts++;
        end
        if (want_inst) begin
            last_inst = exp_inst;
            have_inst = 1'b1;
        end
        if (want_rdata) begin
            last_rdata = exp_rdata;
            have_rdata = 1'b1;
        end
    endtask

    task automatic run_request(input string name, input logic fetch, input logic data,
                               input logic write, input int i_idx, input int d_idx,
                               input mem_pkg::word_t wd, input mem_pkg::word_t wm);
        mem_pkg::word_t exp_inst;
        mem_pkg::word_t exp_rdata;
        wait_idle();
        if (have_inst) begin
            check_value("inst held", last_inst, inst);
        end
        if (have_rdata) begin
            check_value("rdata held", last_rdata, rdata);
        end
        exp_inst = model[i_idx];  // fetch goes ahead of the data side
        if (data && write) begin
            model[d_idx] = merge_masked(model[d_idx], wd, wm);
        end
        exp_rdata = model[d_idx];
        drive_request(fetch, data, write, i_idx, d_idx, wd, wm);
        release_request();
        collect_responses(name, fetch, data && !write, exp_inst, exp_rdata);
    endtask

    // fetch plus write presented while halted, released later
    task automatic halt_test();
        int             i_idx;
        int             d_idx;
        mem_pkg::word_t wd;
        mem_pkg::word_t wm;
        mem_pkg::word_t exp_inst;
        mem_pkg::word_t old_word;
        i_idx = random_index();
        d_idx = random_index();
        wd = random_word();
        wm = random_word();
        wait_idle();
        exp_inst = model[i_idx];
        old_word = model[d_idx];
        model[d_idx] = merge_masked(old_word, wd, wm);
        @(posedge clk);
        halt <= 1'b1;
        drive_request(1'b1, 1'b1, 1'b1, i_idx, d_idx, wd, wm);
        repeat (8) begin
            @(negedge clk);
            check_value("halt inst_valid", 32'd0, inst_valid);
            check_value("halt rdata_valid", 32'd0, rdata_valid);
            check_value("halt memory word", old_word,
                        mem_subsys_inst.main_memory_inst.mem[d_idx]);
        end
        @(posedge clk);
        halt <= 1'b0;
        release_request();
        collect_responses("halt fetch", 1'b1, 1'b0, exp_inst, 32'd0);
        run_request("halt load", 1'b0, 1'b1, 1'b0, 0, d_idx, 32'd0, 32'd0);
    endtask

    initial begin
        int             op;
        int             i_idx;
        int             d_idx;
        mem_pkg::word_t wd;
        mem_pkg::word_t wm;
        rng_state = 32'd51873;
        value_errors = 0;
        other_errors = 0;
        timeouts = 0;
        have_inst = 1'b0;
        have_rdata = 1'b0;
        rst = 1'b1;
        halt = 1'b0;
        inst_start = 1'b0;
        i_addr = '0;
        d_cmd_start = 1'b0;
        d_cmd_write = 1'b0;
        d_addr = '0;
        wdata = '0;
        wmask = '0;
        for (int i = 0; i < `MEM_WORDS; i++) begin
            model[i] = '0;
        end
        repeat (10) @(posedge clk);
        rst <= 1'b0;

        @(negedge clk);
        check_value("reset inst_ready", 32'd1, inst_ready);
        check_value("reset d_cmd_ready", 32'd1, d_cmd_ready);
        check_value("reset inst_valid", 32'd0, inst_valid);
        check_value("reset rdata_valid", 32'd0, rdata_valid);

        // two masked writes merge onto one word
        d_idx = random_index();
        for (int k = 0; k < 2; k++) begin
            wd = random_word();
            wm = random_word();
            run_request("masked write", 1'b0, 1'b1, 1'b1, 0, d_idx, wd, wm);
        end
        run_request("load after write", 1'b0, 1'b1, 1'b0, 0, d_idx, 32'd0, 32'd0);
        run_request("fetch", 1'b1, 1'b0, 1'b0, d_idx, 0, 32'd0, 32'd0);

        i_idx = random_index();
        run_request("pair fetch+load", 1'b1, 1'b1, 1'b0, i_idx, d_idx, 32'd0, 32'd0);
        wd = random_word();
        wm = random_word();
        run_request("pair fetch+write", 1'b1, 1'b1, 1'b1, d_idx, d_idx, wd, wm);
        run_request("pair load after write", 1'b0, 1'b1, 1'b0, 0, d_idx, 32'd0, 32'd0);

        if (timeouts == 0) begin
            halt_test();
        end

        for (int k = 0; k < RANDOM_OPS && timeouts == 0; k++) begin
            op = int'(random_word() % 5);
            i_idx = random_index();
            d_idx = random_index();
            wd = random_word();
            wm = random_word();
            case (op)
                0: run_request("random fetch", 1'b1, 1'b0, 1'b0, i_idx, d_idx, wd, wm);
                1: run_request("random load", 1'b0, 1'b1, 1'b0, i_idx, d_idx, wd, wm);
                2: run_request("random write", 1'b0, 1'b1, 1'b1, i_idx, d_idx, wd, wm);
                3: run_request("random fetch+load", 1'b1, 1'b1, 1'b0, i_idx, d_idx, wd, wm);
                default: run_request("random fetch+write", 1'b1, 1'b1, 1'b1, i_idx, d_idx,
                                     wd, wm);
            endcase
        end
        wait_idle();

        $display("summary: %0d mismatches, %0d protocol errors, %0d timeouts, %0d sva failures",
                 value_errors, other_errors, timeouts,
                 mem_subsys_inst.mem_subsys_sva_inst.assert_failures);
        if (value_errors + other_errors + timeouts
            + mem_subsys_inst.mem_subsys_sva_inst.assert_failures == 0) begin
            $display("SIMULATION PASSED");
        end else begin
            $display("SIMULATION FAILED");
        end
        $finish;
    end

endmodule

// ==== tests/tb_clock_gen.sv ====
`timescale 1ns/1ns

module tb_clock_gen #(
    parameter int PERIOD_NS = 10
) (
    output logic clk
);

    initial begin
        clk = 1'b0;
        forever begin
            #(PERIOD_NS / 2) clk = ~clk;  // half period per phase
        end
    end

endmodule
